//--- dv/line_cases.hex
// port (0, 1, 2 = both on one cycle)  op (1 write, 0 read)  line address  expected err
// with port 2 the second port takes the next line (address + 20); a port of f ends the list
0 1 30000000 0   // port 0 write then read back
0 0 30000000 0
1 0 30000000 0   // port 1 sees the same memory
0 1 30000020 0
1 1 30000040 0
1 0 30000040 0
0 0 30000040 0
1 0 30000020 0
2 1 30000100 0   // first tie
2 0 30000100 0   // second tie
2 0 30000000 0
0 1 30000400 1   // one line past the window, would alias line 0
0 0 30000000 0
1 1 2fffffe0 1   // just below the window
1 0 30000000 0
0 0 30000400 1   // missed read gives zero words
1 0 50000000 1
2 1 300003c0 0   // top two lines of the window
2 0 300003c0 0
0 1 30000000 0   // overwrite line 0
1 0 30000000 0
2 1 30000400 1   // both ports outside the window
1 0 300003e0 0
0 0 30000020 0
2 0 30000000 0
f 0 0 0

//--- dv/tb_line_fabric.sv
`timescale 1ns/1ps

module tb_line_fabric;

  import line_bus_pkg::*;

  localparam int          block_size   = 8;
  localparam int          max_cases    = 64;
  localparam int          done_timeout = 60;              // cycles, enough for a tie pair
  localparam logic [31:0] lfsr_mask    = 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] end_marker   = 32'h0000_000f;

  typedef word_t [block_size-1:0] line_t;

  logic        clk = 1'b0;
  logic        rst;
  logic        line_req_0;
  logic        line_write_0;
  word_t       line_addr_0;
  line_t       line_wdata_0;
  logic        busy_0;
  logic        done_0;
  logic        line_err_0;
  line_t       line_rdata_0;
  logic        line_req_1;
  logic        line_write_1;
  word_t       line_addr_1;
  line_t       line_wdata_1;
  logic        busy_1;
  logic        done_1;
  logic        line_err_1;
  line_t       line_rdata_1;

  logic [31:0] case_mem [4*max_cases];   // four columns per case
  line_t       ref_lines [logic [31:0]];  // last data written, by line address
  logic [31:0] lfsr_state = 32'h9915;
  int          tie_count  = 0;
  int          case_count;

  line_fabric_top i_dut (
    .clk(clk), .rst(rst),
    .line_req_0(line_req_0), .line_write_0(line_write_0),
    .line_addr_0(line_addr_0), .line_wdata_0(line_wdata_0),
    .busy_0(busy_0), .done_0(done_0), .line_err_0(line_err_0), .line_rdata_0(line_rdata_0),
    .line_req_1(line_req_1), .line_write_1(line_write_1),
    .line_addr_1(line_addr_1), .line_wdata_1(line_wdata_1),
    .busy_1(busy_1), .done_1(done_1), .line_err_1(line_err_1), .line_rdata_1(line_rdata_1)
  );

  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic advance_cycle();
    @(posedge clk);
    #2;   // outputs settled, inputs change here
  endtask

  task automatic stop_on_failure();
    $display(">>> FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic expect_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic check_idle_outputs();
    expect_equal("busy_0", 32'd0, 32'(busy_0));
    expect_equal("busy_1", 32'd0, 32'(busy_1));
    expect_equal("done_0", 32'd0, 32'(done_0));
    expect_equal("done_1", 32'd0, 32'(done_1));
  endtask

  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ lfsr_mask;
    else
      return s >> 1;
  endfunction

  // one lfsr step per data bit
  function automatic word_t random_word();
    word_t w;
    for (int i = 0; i < 32; i++)
    begin
      w[i]       = lfsr_state[0];
      lfsr_state = next_lfsr(lfsr_state);
    end
    return w;
  endfunction

  task automatic start_line(input int port, input logic write, input word_t addr,
                            input line_t wdata);
    if (port == 0)
    begin
      line_req_0   = 1'b1;
      line_write_0 = write;
      line_addr_0  = addr;
      line_wdata_0 = wdata;
    end
    else
    begin
      line_req_1   = 1'b1;
      line_write_1 = write;
      line_addr_1  = addr;
      line_wdata_1 = wdata;
    end
  endtask

  task automatic wait_for_done(input logic want_0, input logic want_1,
                               output int cycle_0, output int cycle_1);
    int   cycles;
    logic seen_0;
    logic seen_1;
    cycles  = 0;
    seen_0  = !want_0;
    seen_1  = !want_1;
    cycle_0 = -1;
    cycle_1 = -1;
    while (!(seen_0 && seen_1))
    begin
      advance_cycle();
      line_req_0 = 1'b0;   // strobe lasts one cycle
      line_req_1 = 1'b0;
      cycles++;
      if (cycles > done_timeout)
      begin
        if (!seen_0)
          $display("timeout: port 0 never signalled done");
        if (!seen_1)
          $display("timeout: port 1 never signalled done");
        stop_on_failure();
      end
      if (!seen_0)
      begin
        expect_equal("busy_0", 32'(!done_0), 32'(busy_0));   // busy drops with done
        seen_0  = done_0;
        cycle_0 = cycles;
      end
      else
        expect_equal("done_0", 32'd0, 32'(done_0));
      if (!seen_1)
      begin
        expect_equal("busy_1", 32'(!done_1), 32'(busy_1));
        seen_1  = done_1;
        cycle_1 = cycles;
      end
      else
        expect_equal("done_1", 32'd0, 32'(done_1));
    end
  endtask

  task automatic check_line_result(input int port, input logic write, input word_t addr,
                                   input line_t wdata, input logic err_exp);
    logic  err;
    line_t rdata;
    string tag;
    err   = (port == 0) ? line_err_0 : line_err_1;
    rdata = (port == 0) ? line_rdata_0 : line_rdata_1;
    tag   = (port == 0) ? "_0" : "_1";
    expect_equal({"line_err", tag}, 32'(err_exp), 32'(err));
    if (err_exp)
    begin
      if (!write)   // a missed read returns zero words
        for (int i = 0; i < block_size; i++)
          expect_equal($sformatf("line_rdata%s[%0d]", tag, i), 32'd0, rdata[i]);
    end
    else if (write)
      ref_lines[addr] = wdata;
    else
    begin
      assert (ref_lines.exists(addr))
      else
      begin
        $display("case reads line %h that was never written", addr);
        stop_on_failure();
      end
      for (int i = 0; i < block_size; i++)
        expect_equal($sformatf("line_rdata%s[%0d]", tag, i), ref_lines[addr][i], rdata[i]);
    end
  endtask

  //////////////////////////////////////////////////
  // cases
  //////////////////////////////////////////////////

  task automatic run_case(input int n);
    int    port_sel;
    logic  write;
    word_t addr;
    logic  err_exp;
    line_t wdata_0;
    line_t wdata_1;
    int    cycle_0;
    int    cycle_1;
    port_sel = int'(case_mem[4*n]);
    write    = case_mem[4*n+1][0];
    addr     = case_mem[4*n+2];
    err_exp  = case_mem[4*n+3][0];
    wdata_0  = '0;
    wdata_1  = '0;
    for (int i = 0; i < block_size; i++)
    begin
      if (write)
        wdata_0[i] = random_word();
      if (write && port_sel == 2)
        wdata_1[i] = random_word();
    end
    if (port_sel == 2)
    begin
      start_line(0, write, addr, wdata_0);
      start_line(1, write, addr + 32'h20, wdata_1);   // port 1 takes the next line
      wait_for_done(1'b1, 1'b1, cycle_0, cycle_1);
      // ties alternate, port 0 wins the first one
      expect_equal("port done first", 32'(tie_count % 2), (cycle_0 < cycle_1) ? 32'd0 : 32'd1);
      tie_count++;
      check_line_result(0, write, addr, wdata_0, err_exp);
      check_line_result(1, write, addr + 32'h20, wdata_1, err_exp);
    end
    else
    begin
      start_line(port_sel, write, addr, wdata_0);
      wait_for_done(port_sel == 0, port_sel == 1, cycle_0, cycle_1);
      check_line_result(port_sel, write, addr, wdata_0, err_exp);
    end
  endtask

  initial
  begin
    rst          = 1'b1;
    line_req_0   = 1'b0;
    line_write_0 = 1'b0;
    line_addr_0  = '0;
    line_wdata_0 = '0;
    line_req_1   = 1'b0;
    line_write_1 = 1'b0;
    line_addr_1  = '0;
    line_wdata_1 = '0;
    for (int i = 0; i < 4*max_cases; i++)
      case_mem[i] = end_marker;
    $readmemh("dv/line_cases.hex", case_mem);
    repeat (16)
    begin
      advance_cycle();
      check_idle_outputs();
    end
    rst = 1'b0;
    repeat (4)
    begin
      advance_cycle();
      check_idle_outputs();   // nothing moves before the first request
    end
    case_count = 0;
    while (case_count < max_cases && case_mem[4*case_count] != end_marker)
    begin
      run_case(case_count);
      case_count++;
    end
    assert (case_count > 0)
    else
    begin
      $display("no cases were read from dv/line_cases.hex");
      stop_on_failure();
    end
    $display("%0d cases run, %0d ties", case_count, tie_count);
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- hw/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   want_0,
  input  logic                   want_1,
  input  line_bus_pkg::bus_req_t req_0,
  input  line_bus_pkg::bus_req_t req_1,
  input  line_bus_pkg::bus_rsp_t rsp_mem,
  output logic                   grant_0,
  output logic                   grant_1,
  output line_bus_pkg::bus_req_t req_mem,
  output line_bus_pkg::bus_rsp_t rsp_0,
  output line_bus_pkg::bus_rsp_t rsp_1
);

  logic held;          // current owner still in its burst
  logic tie;
  logic last_served;   // port that won the last contended round

  assign held = (grant_0 && want_0) || (grant_1 && want_1);
  assign tie  = want_0 && want_1;

  //////////////////////////////////////////////////
  // grant
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant_0     <= 1'b0;
      grant_1     <= 1'b0;
      last_served <= 1'b1;   // first tie goes to port 0
    end
    else if (!held)
    begin
      if (tie)
      begin
        grant_0     <= last_served;
        grant_1     <= !last_served;
        last_served <= !last_served;   // priority flips only when both compete
      end
      else
      begin
        grant_0 <= want_0;   // single requester or idle bus
        grant_1 <= want_1;
      end
    end
  end

  //////////////////////////////////////////////////
  // beat and response routing
  //////////////////////////////////////////////////

  always_comb
  begin
    req_mem = '0;
    if (grant_0)
      req_mem = req_0;
    else if (grant_1)
      req_mem = req_1;
  end

  always_comb
  begin
    rsp_0 = '0;   // the idle master never sees an ack
    rsp_1 = '0;
    if (grant_0)
      rsp_0 = rsp_mem;
    if (grant_1)
      rsp_1 = rsp_mem;
  end

  assert property (@(posedge clk) disable iff (rst) !(grant_0 && grant_1))
    else $error("both grants high");

  // masters only drive beats while they own the bus, so the mux never drops one
  assert property (@(posedge clk) disable iff (rst)
    !(req_0.valid && !grant_0) && !(req_1.valid && !grant_1))
    else $error("valid beat from a master without grant");

endmodule

//--- hw/line_burst_master.sv
`timescale 1ns/1ps

module line_burst_master #(
  parameter int block_size = 8
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 line_req,
  input  logic                                 line_write,
  input  line_bus_pkg::word_t                  line_addr,
  input  line_bus_pkg::word_t [block_size-1:0] line_wdata,
  input  logic                                 grant,
  input  line_bus_pkg::bus_rsp_t               rsp,
  output logic                                 busy,
  output logic                                 done,
  output logic                                 line_err,
  output line_bus_pkg::word_t [block_size-1:0] line_rdata,
  output logic                                 bus_want,
  output line_bus_pkg::bus_req_t               req
);

  import line_bus_pkg::*;

  localparam int cnt_w = beat_bits + 1;   // counts up to block_size inclusive

  logic                   write_q;      // latched operation
  bus_addr_u              addr_q;       // latched line address
  word_t [block_size-1:0] wdata_q;      // latched write line
  logic [cnt_w-1:0]       issue_cnt;    // beats sent
  logic [cnt_w-1:0]       ack_cnt;      // beats answered
  logic                   err_acc;      // OR of beat errors so far
  logic                   issue;
  logic                   last_ack;
  logic                   beat_valid;
  bus_addr_u              beat_addr;
  word_t                  beat_wdata;

  initial assert (block_size == (1 << beat_bits))
    else $fatal(1, "block_size %0d does not match beat_bits %0d", block_size, beat_bits);

  // one beat per cycle while we own the bus, no waiting on acks
  assign issue    = busy && grant && (issue_cnt < cnt_w'(block_size));
  assign last_ack = rsp.ack && (ack_cnt == cnt_w'(block_size - 1));
  assign bus_want = busy;   // held until the cycle after the last ack

  assign req.valid = beat_valid;
  assign req.write = write_q;
  assign req.addr  = beat_addr;
  assign req.wdata = beat_wdata;

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy       <= 1'b0;
      done       <= 1'b0;
      line_err   <= 1'b0;
      err_acc    <= 1'b0;
      issue_cnt  <= '0;
      ack_cnt    <= '0;
      beat_valid <= 1'b0;
    end
    else
    begin
      done       <= last_ack;   // one cycle pulse
      beat_valid <= issue;
      if (line_req)
      begin
        busy      <= 1'b1;
        err_acc   <= 1'b0;
        issue_cnt <= '0;
        ack_cnt   <= '0;
      end
      else
      begin
        if (issue)
          issue_cnt <= issue_cnt + 1'b1;
        if (rsp.ack)
        begin
          ack_cnt <= ack_cnt + 1'b1;
          err_acc <= err_acc | rsp.err;
        end
        if (last_ack)
        begin
          busy     <= 1'b0;
          line_err <= err_acc | rsp.err;   // includes the final beat
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (line_req)
    begin
      write_q    <= line_write;
      addr_q.raw <= line_addr;
      wdata_q    <= line_wdata;
    end
    if (issue)
    begin
      beat_addr.beat.line_base <= addr_q.beat.line_base;
      beat_addr.beat.index     <= issue_cnt[beat_bits-1:0];
      beat_addr.beat.byte_off  <= 2'b00;
      beat_wdata               <= wdata_q[issue_cnt[beat_bits-1:0]];
    end
    if (rsp.ack)
      line_rdata[ack_cnt[beat_bits-1:0]] <= rsp.rdata;   // acks return in issue order
  end

  // a new line may only start once the previous one is done
  assert property (@(posedge clk) disable iff (rst) line_req |-> !busy)
    else $error("line_req while busy");

endmodule

//--- hw/line_bus_pkg.sv
package line_bus_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int addr_width = 32;   // byte address
  localparam int data_width = 32;   // one bus word
  localparam int beat_bits  = 3;    // beat index of a line of 8 words

  typedef logic [data_width-1:0] word_t;

  //////////////////////////////////////////////////
  // address views
  //////////////////////////////////////////////////

  // beat view used by the masters to walk through a line
  typedef struct packed {
    logic [addr_width-beat_bits-3:0] line_base;  // line aligned upper bits
    logic [beat_bits-1:0]            index;      // word inside the line
    logic [1:0]                      byte_off;   // always zero on the bus
  } beat_addr_t;

  // the same 32 bits read as a plain byte address or split per beat
  typedef union packed {
    logic [addr_width-1:0] raw;    // window test and base subtraction
    beat_addr_t            beat;   // line base plus beat index
  } bus_addr_u;

  //////////////////////////////////////////////////
  // beat bus
  //////////////////////////////////////////////////

  // one beat from a master towards the memory
  typedef struct packed {
    logic      valid;   // beat present this cycle
    logic      write;   // store wdata instead of reading
    bus_addr_u addr;
    word_t     wdata;
  } bus_req_t;

  // one cycle after each valid beat
  typedef struct packed {
    logic  ack;     // beat complete
    logic  err;     // address missed the window
    word_t rdata;   // zero on writes and errors
  } bus_rsp_t;

endpackage

//--- hw/line_fabric_top.sv
`timescale 1ns/1ps

module line_fabric_top #(
  parameter int          block_size = 8,
  parameter int          mem_words  = 256,
  parameter logic [31:0] mem_base   = 32'h3000_0000
) (
  input  logic                                 clk,
  input  logic                                 rst,
  // port 0 instruction lines
  input  logic                                 line_req_0,
  input  logic                                 line_write_0,
  input  line_bus_pkg::word_t                  line_addr_0,
  input  line_bus_pkg::word_t [block_size-1:0] line_wdata_0,
  output logic                                 busy_0,
  output logic                                 done_0,
  output logic                                 line_err_0,
  output line_bus_pkg::word_t [block_size-1:0] line_rdata_0,
  // port 1 data lines
  input  logic                                 line_req_1,
  input  logic                                 line_write_1,
  input  line_bus_pkg::word_t                  line_addr_1,
  input  line_bus_pkg::word_t [block_size-1:0] line_wdata_1,
  output logic                                 busy_1,
  output logic                                 done_1,
  output logic                                 line_err_1,
  output line_bus_pkg::word_t [block_size-1:0] line_rdata_1
);

  import line_bus_pkg::*;

  logic     want_0;
  logic     want_1;
  logic     grant_0;
  logic     grant_1;
  bus_req_t req_0;
  bus_req_t req_1;
  bus_req_t req_mem;   // granted master's beats
  bus_rsp_t rsp_0;
  bus_rsp_t rsp_1;
  bus_rsp_t rsp_mem;

  //////////////////////////////////////////////////
  // masters
  //////////////////////////////////////////////////

  line_burst_master #(.block_size(block_size)) i_master_0 (
    .clk(clk), .rst(rst),
    .line_req(line_req_0), .line_write(line_write_0),
    .line_addr(line_addr_0), .line_wdata(line_wdata_0),
    .grant(grant_0), .rsp(rsp_0),
    .busy(busy_0), .done(done_0), .line_err(line_err_0),
    .line_rdata(line_rdata_0), .bus_want(want_0), .req(req_0)
  );

  line_burst_master #(.block_size(block_size)) i_master_1 (
    .clk(clk), .rst(rst),
    .line_req(line_req_1), .line_write(line_write_1),
    .line_addr(line_addr_1), .line_wdata(line_wdata_1),
    .grant(grant_1), .rsp(rsp_1),
    .busy(busy_1), .done(done_1), .line_err(line_err_1),
    .line_rdata(line_rdata_1), .bus_want(want_1), .req(req_1)
  );

  //////////////////////////////////////////////////
  // shared bus and memory
  //////////////////////////////////////////////////

  bus_arbiter i_arbiter (
    .clk(clk), .rst(rst),
    .want_0(want_0), .want_1(want_1),
    .req_0(req_0), .req_1(req_1), .rsp_mem(rsp_mem),
    .grant_0(grant_0), .grant_1(grant_1),
    .req_mem(req_mem), .rsp_0(rsp_0), .rsp_1(rsp_1)
  );

  window_memory #(.mem_words(mem_words), .mem_base(mem_base)) i_memory (
    .clk(clk), .rst(rst),
    .req(req_mem),
    .rsp(rsp_mem)
  );

endmodule

//--- hw/window_memory.sv
`timescale 1ns/1ps

module window_memory #(
  parameter int          mem_words = 256,
  parameter logic [31:0] mem_base  = 32'h3000_0000
) (
  input  logic                   clk,
  input  logic                   rst,
  input  line_bus_pkg::bus_req_t req,
  output line_bus_pkg::bus_rsp_t rsp
);

  import line_bus_pkg::*;

  localparam int    idx_w     = $clog2(mem_words);
  localparam word_t win_bytes = word_t'(mem_words * 4);   // window size in bytes

  word_t            mem [mem_words];
  word_t            offset;      // byte offset into the window
  logic             in_window;
  logic [idx_w-1:0] word_idx;
  logic             ack_q;
  logic             err_q;
  word_t            rdata_q;

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////

  assign offset    = req.addr.raw - mem_base;
  assign in_window = (req.addr.raw >= mem_base) && (offset < win_bytes);
  assign word_idx  = offset[idx_w+1:2];   // drop the byte offset

  assign rsp.ack   = ack_q;
  assign rsp.err   = err_q;
  assign rsp.rdata = rdata_q;

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end
    else
    begin
      ack_q <= req.valid;   // never stalls
      err_q <= req.valid && !in_window;
    end
  end

  // storage and read data
  always_ff @(posedge clk)
  begin
    if (req.valid && req.write && in_window)
      mem[word_idx] <= req.wdata;
    if (req.valid && !req.write && in_window)
      rdata_q <= mem[word_idx];
    else
      rdata_q <= '0;   // writes and misses return zero
  end

endmodule

//--- list.f
hw/line_bus_pkg.sv
hw/line_burst_master.sv
hw/bus_arbiter.sv
hw/window_memory.sv
hw/line_fabric_top.sv
dv/tb_line_fabric.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the line fabric testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

top=tb_line_fabric
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$top" -f list.f -o "$top"

# exit code ignored here so that the log is always scanned
./obj_dir/"$top" > "$log" 2>&1 || true
cat "$log"

if grep -q ">>> FAIL" "$log"; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q ">>> PASS" "$log"; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
